// File: tests/prog_input.txt
# lane m d lock_delay expect, decimal, expect is ok or timeout
# lock_delay 0 sends pll_reset_req and a command that must be dropped
0 4 2 10 ok
1 16 1 25 ok
2 255 255 3 ok
3 1 8 40 ok
1 7 3 200 timeout
2 12 5 8 ok
2 9 9 0 ok
0 33 66 150 timeout
3 200 100 1 ok
1 2 3 60 ok

// File: sources.f
src/clk_prog_pkg.sv
src/clk_supervisor.sv
src/prog_serializer.sv
src/prog_sequencer.sv
src/clk_prog_top.sv
tests/clkgen_model.sv
tests/prog_monitor.sv
tests/tb_clk_prog.sv

// File: Makefile
# Verilator flow for the clock programming path

VERILATOR ?= verilator
TB_TOP    ?= tb_clk_prog
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_clk_prog.sv
`timescale 1ns/1ps

module tb_clk_prog;

	localparam int RESET_HOLD   = 32;
	localparam int LOCK_TIMEOUT = 64;

	// DUT host side
	logic                    IFCLK;
	logic                    rst;
	logic                    cmd_valid;
	clk_prog_pkg::prog_cmd_t cmd;
	logic                    pll_reset_req;
	logic                    ready;
	logic                    prog_done;
	logic                    prog_err;
	// DUT generator side
	logic [3:0]              progen;
	logic                    progdata;
	logic                    progclk;
	logic                    pll_reset;
	logic                    progdone_inv;

	// Generator model and monitor side
	int                      lock_delay;
	logic                    exp_push;
	clk_prog_pkg::prog_cmd_t exp_cmd;
	logic                    exp_timeout;
	int                      mon_errors;
	int                      mon_pending;

	// One entry per line of the stimulus file
	int                      t_lane[$];
	int                      t_m[$];
	int                      t_d[$];
	int                      t_delay[$];
	logic                    t_timeout[$];

	int                      tb_errors;
	int                      n_cmds;
	int                      cycles;
	int                      limit;

	clk_prog_top #(
		.RESET_HOLD(RESET_HOLD),
		.LOCK_TIMEOUT(LOCK_TIMEOUT)
	) UUT (
		.IFCLK(IFCLK),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.pll_reset_req(pll_reset_req),
		.ready(ready),
		.prog_done(prog_done),
		.prog_err(prog_err),
		.progen(progen),
		.progdata(progdata),
		.progclk(progclk),
		.pll_reset(pll_reset),
		.progdone_inv(progdone_inv)
	);

	// Stands in for the four programmable generators
	clkgen_model #(
		.LOCK_TIMEOUT(LOCK_TIMEOUT)
	) gen (
		.IFCLK(IFCLK),
		.rst(rst),
		.progen(progen),
		.lock_delay(lock_delay),
		.progdone_inv(progdone_inv)
	);

	// Frame decoder and checker
	prog_monitor #(
		.RESET_HOLD(RESET_HOLD)
	) mon (
		.IFCLK(IFCLK),
		.rst(rst),
		.progen(progen),
		.progdata(progdata),
		.progclk(progclk),
		.ready(ready),
		.pll_reset(pll_reset),
		.pll_reset_req(pll_reset_req),
		.prog_done(prog_done),
		.prog_err(prog_err),
		.exp_push(exp_push),
		.exp_cmd(exp_cmd),
		.exp_timeout(exp_timeout),
		.errors(mon_errors),
		.pending(mon_pending)
	);

	// 100 MHz IFCLK
	initial begin
		IFCLK = 1'b0;
		forever #5 IFCLK = ~IFCLK;
	end

	// *************************************************************************
	// Watchdog
	// *************************************************************************

	always @(posedge IFCLK) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Watchdog stopped the run after %0d cycles, the DUT did not finish", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// *************************************************************************
	// Stimulus file
	// *************************************************************************

	// Columns are lane, m, d, lock delay and ok or timeout
	task automatic read_tests();
		int          fd;
		int          n;
		int          lane;
		int          m;
		int          d;
		int          dly;
		string       line;
		logic [63:0] res;
		fd = $fopen("tests/prog_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file tests/prog_input.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Blank lines and comment lines
			if (n < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %d %d %d %s", lane, m, d, dly, res);
			if (n != 5 || (res != "ok" && res != "timeout")) begin
				$display("Unreadable line in the stimulus file: %s", line);
				tb_errors++;
			end else begin
				t_lane.push_back(lane);
				t_m.push_back(m);
				t_d.push_back(d);
				t_delay.push_back(dly);
				t_timeout.push_back(res == "timeout");
			end
		end
		$fclose(fd);
	endtask

	// Command word from one file line
	function automatic clk_prog_pkg::prog_cmd_t make_cmd(input int i);
		clk_prog_pkg::prog_cmd_t c;
		c.lane = clk_prog_pkg::lane_t'(t_lane[i]);
		c.m    = clk_prog_pkg::ratio_t'(t_m[i]);
		c.d    = clk_prog_pkg::ratio_t'(t_d[i]);
		return c;
	endfunction

	// Returns on an edge where ready was high
	task automatic wait_ready();
		while (!ready) begin
			@(posedge IFCLK);
		end
	endtask

	// One command, monitor told on the accept edge
	task automatic run_command(input int i);
		clk_prog_pkg::prog_cmd_t c;
		c = make_cmd(i);
		wait_ready();
		lock_delay  <= t_delay[i];
		cmd         <= c;
		cmd_valid   <= 1'b1;
		exp_cmd     <= c;
		exp_timeout <= t_timeout[i];
		exp_push    <= 1'b1;
		@(posedge IFCLK);
		cmd_valid <= 1'b0;
		exp_push  <= 1'b0;
		n_cmds++;
		// Old prog_err is gone one edge after the accept
		@(posedge IFCLK);
		while (!(prog_done || prog_err)) begin
			@(posedge IFCLK);
		end
	endtask

	// PLL reset request, then a command that must be dropped
	task automatic reset_pll(input int i);
		pll_reset_req <= 1'b1;
		@(posedge IFCLK);
		pll_reset_req <= 1'b0;
		repeat (4) @(posedge IFCLK);
		cmd       <= make_cmd(i);
		cmd_valid <= 1'b1;
		@(posedge IFCLK);
		cmd_valid <= 1'b0;
		wait_ready();
	endtask

	// *************************************************************************
	// Main sequence
	// *************************************************************************

	initial begin
		rst           = 1'b1;
		cmd_valid     = 1'b0;
		cmd           = '0;
		pll_reset_req = 1'b0;
		lock_delay    = 0;
		exp_push      = 1'b0;
		exp_cmd       = '0;
		exp_timeout   = 1'b0;
		tb_errors     = 0;
		n_cmds        = 0;
		cycles        = 0;
		limit         = 0;
		read_tests();
		// Every line gets the lock timeout plus room for three frames
		limit = (t_lane.size() > 0 ? t_lane.size() : 1) * (LOCK_TIMEOUT + 64);
		repeat (10) @(posedge IFCLK);
		rst <= 1'b0;
		// Delay 0 marks a PLL reset line
		foreach (t_lane[i]) begin
			if (t_delay[i] == 0) begin
				reset_pll(i);
			end else begin
				run_command(i);
			end
		end
		repeat (8) @(posedge IFCLK);
		if (mon_pending != 0) begin
			$display("%0d accepted commands never ended in prog_done or prog_err", mon_pending);
			tb_errors++;
		end
		$display("Ran %0d commands: %0d monitor errors, %0d testbench errors",
			n_cmds, mon_errors, tb_errors);
		if (mon_errors == 0 && tb_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tests/prog_monitor.sv
`timescale 1ns/1ps

module prog_monitor #(
	parameter int RESET_HOLD = 32
) (
	input  logic                    IFCLK,
	input  logic                    rst,
	input  logic [3:0]              progen,
	input  logic                    progdata,
	input  logic                    progclk,
	input  logic                    ready,
	input  logic                    pll_reset,
	input  logic                    pll_reset_req,
	input  logic                    prog_done,
	input  logic                    prog_err,
	// Expected command, pushed on the edge where the DUT accepts it
	input  logic                    exp_push,
	input  clk_prog_pkg::prog_cmd_t exp_cmd,
	input  logic                    exp_timeout,
	output int                      errors,
	output int                      pending
);

	clk_prog_pkg::prog_cmd_t q_cmd[$];
	logic                    q_timeout[$];
	// Cycles since rst or the last PLL reset request
	int                      since;
	// Received bits, newest in the top bit
	logic [9:0]              word;
	int                      nbits;
	// 0 is D, 1 is M, 2 is GO, 3 waits for lock
	int                      fidx;
	logic                    lane_bad;
	logic                    done_d;
	logic                    err_d;

	// Load frame, first bit received is opcode bit 0
	task automatic check_load(input string name, input logic [1:0] op, input logic [7:0] val);
		if (nbits != 10) begin
			$display("Mismatch progen length of %s frame: expected %0h, got %0h", name, 10, nbits);
			errors++;
		end else begin
			if (word[1:0] != op) begin
				$display("Mismatch progdata opcode of %s frame: expected %0h, got %0h",
					name, op, word[1:0]);
				errors++;
			end
			if (word[9:2] != val) begin
				$display("Mismatch progdata payload of %s frame: expected %0h, got %0h",
					name, val, word[9:2]);
				errors++;
			end
		end
	endtask

	// progen has dropped, compare the frame with its place in the sequence
	task automatic close_frame();
		clk_prog_pkg::prog_cmd_t c;
		if (q_cmd.size() == 0 || fidx > 2) begin
			$display("Frame of %0d bits sent with no command in progress", nbits);
			errors++;
		end else begin
			c = q_cmd[0];
			// Payload is the ratio minus one
			if (fidx == 0) begin
				check_load("D", 2'b01, c.d - 8'd1);
			end else if (fidx == 1) begin
				check_load("M", 2'b11, c.m - 8'd1);
			end else if (nbits != 1) begin
				$display("Mismatch progen length of GO frame: expected %0h, got %0h", 1, nbits);
				errors++;
			end else if (word[9] != 1'b0) begin
				$display("Mismatch progdata of GO frame: expected %0h, got %0h", 0, word[9]);
				errors++;
			end
			fidx++;
		end
		nbits    = 0;
		lane_bad = 1'b0;
	endtask

	always @(posedge IFCLK) begin
		if (rst) begin
			since    = 0;
			nbits    = 0;
			fidx     = 0;
			lane_bad = 1'b0;
			done_d   = 1'b0;
			err_d    = 1'b0;
			q_cmd.delete();
			q_timeout.delete();
		end else begin
			// *****************************************************************
			// PLL reset hold and ready
			// *****************************************************************
			if (pll_reset_req) begin
				since = 0;
			end else begin
				if (since < RESET_HOLD && (!pll_reset || ready)) begin
					$display("pll_reset low or ready high %0d cycles into a %0d cycle hold",
						since, RESET_HOLD);
					errors++;
				end
				if (since >= RESET_HOLD && pll_reset) begin
					$display("pll_reset still high %0d cycles after it was raised", since);
					errors++;
				end
				if (since < 1000000) begin
					since++;
				end
			end
			if (exp_push) begin
				q_cmd.push_back(exp_cmd);
				q_timeout.push_back(exp_timeout);
			end
			// *****************************************************************
			// Frame decode, progclk high means the bit was stable a full period
			// *****************************************************************
			if (progclk && progen != '0) begin
				if (nbits == 0 && fidx == 0 && prog_err) begin
					$display("prog_err still high while a new command is being sent");
					errors++;
				end
				// Only the commanded lane may be high
				if (q_cmd.size() != 0 && !lane_bad && progen != (4'b0001 << q_cmd[0].lane)) begin
					$display("Mismatch progen: expected %0h, got %0h",
						4'b0001 << q_cmd[0].lane, progen);
					errors++;
					lane_bad = 1'b1;
				end
				word = {progdata, word[9:1]};
				nbits++;
			end else if (progclk && nbits != 0) begin
				close_frame();
			end
			// *****************************************************************
			// Outcome
			// *****************************************************************
			if (prog_done) begin
				if (done_d) begin
					$display("prog_done stayed high for more than one cycle");
					errors++;
				end else if (fidx != 3) begin
					$display("prog_done pulsed with no command waiting for lock");
					errors++;
				end else begin
					if (q_timeout[0]) begin
						$display("prog_done pulsed where a lock timeout was expected");
						errors++;
					end
					void'(q_cmd.pop_front());
					void'(q_timeout.pop_front());
					fidx = 0;
				end
			end
			if (prog_err && !err_d) begin
				if (fidx != 3) begin
					$display("prog_err rose with no command waiting for lock");
					errors++;
				end else begin
					if (!q_timeout[0]) begin
						$display("prog_err rose where the generator was expected to lock");
						errors++;
					end
					void'(q_cmd.pop_front());
					void'(q_timeout.pop_front());
					fidx = 0;
				end
			end
			done_d  = prog_done;
			err_d   = prog_err;
			pending = q_cmd.size();
		end
	end

endmodule

// File: tests/clkgen_model.sv
`timescale 1ns/1ps

module clkgen_model #(
	parameter int LOCK_TIMEOUT = 256
) (
	input  logic       IFCLK,
	input  logic       rst,
	input  logic [3:0] progen,
	// Lock time of the generator being programmed, in IFCLK cycles
	input  int         lock_delay,
	output logic       progdone_inv
);

	// The four generators share one done line, so one model serves all lanes
	logic en_d;
	int   high_cnt;
	int   wait_cnt;
	logic waiting;

	always_ff @(posedge IFCLK) begin
		if (rst) begin
			progdone_inv <= 1'b0;
			en_d         <= 1'b0;
			high_cnt     <= 0;
			wait_cnt     <= 0;
			waiting      <= 1'b0;
		end else begin
			en_d <= (progen != '0);
			if (progen != '0) begin
				// Length of the current frame in IFCLK cycles
				high_cnt <= high_cnt + 1;
			end else begin
				high_cnt <= 0;
				// GO is one progclk period long, a load frame is ten
				if (en_d && high_cnt < 4) begin
					progdone_inv <= 1'b1;
					// Too long a delay means the generator never locks
					waiting      <= (lock_delay <= LOCK_TIMEOUT);
					wait_cnt     <= lock_delay;
				end else if (waiting) begin
					if (wait_cnt <= 1) begin
						progdone_inv <= 1'b0;
						waiting      <= 1'b0;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
			end
		end
	end

endmodule

// File: src/clk_prog_top.sv
`timescale 1ns/1ps

module clk_prog_top #(
	parameter int RESET_HOLD   = 32,
	parameter int LOCK_TIMEOUT = 256
) (
	input  logic                    IFCLK,
	input  logic                    rst,
	// Host side
	input  logic                    cmd_valid,
	input  clk_prog_pkg::prog_cmd_t cmd,
	input  logic                    pll_reset_req,
	output logic                    ready,
	output logic                    prog_done,
	output logic                    prog_err,
	// Generator side
	output logic [3:0]              progen,
	output logic                    progdata,
	output logic                    progclk,
	output logic                    pll_reset,
	input  logic                    progdone_inv
);

	logic                 sys_ready;
	logic                 frame_start;
	logic                 frame_end;
	clk_prog_pkg::frame_t frame;

	// Start-up delay and PLL reset hold
	clk_supervisor #(
		.RESET_HOLD(RESET_HOLD)
	) supervisor (
		.IFCLK(IFCLK),
		.rst(rst),
		.pll_reset_req(pll_reset_req),
		.pll_reset(pll_reset),
		.sys_ready(sys_ready)
	);

	// Orders D, M and GO, then waits for lock
	prog_sequencer #(
		.LOCK_TIMEOUT(LOCK_TIMEOUT)
	) sequencer (
		.IFCLK(IFCLK),
		.rst(rst),
		.sys_ready(sys_ready),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.frame_end(frame_end),
		.progdone_inv(progdone_inv),
		.ready(ready),
		.frame_start(frame_start),
		.frame(frame),
		.prog_done(prog_done),
		.prog_err(prog_err)
	);

	// Serial program lines
	prog_serializer serializer (
		.IFCLK(IFCLK),
		.rst(rst),
		.frame_start(frame_start),
		.frame(frame),
		.progen(progen),
		.progdata(progdata),
		.progclk(progclk),
		.frame_end(frame_end)
	);

endmodule

// File: src/prog_sequencer.sv
`timescale 1ns/1ps

module prog_sequencer #(
	parameter int LOCK_TIMEOUT = 256
) (
	input  logic                    IFCLK,
	input  logic                    rst,
	input  logic                    sys_ready,
	input  logic                    cmd_valid,
	input  clk_prog_pkg::prog_cmd_t cmd,
	input  logic                    frame_end,
	input  logic                    progdone_inv,
	output logic                    ready,
	output logic                    frame_start,
	output clk_prog_pkg::frame_t    frame,
	output logic                    prog_done,
	output logic                    prog_err
);

	// progen low time between frames, 2 progclk periods
	localparam int GAP_CYCLES = 4;
	// frame_end lands 2 cycles after the drop, serializer pickup takes 1 more
	localparam int GAP_WAIT = GAP_CYCLES - 3;
	localparam int GW = $clog2(GAP_CYCLES);
	localparam int LW = $clog2(LOCK_TIMEOUT + 1);

	clk_prog_pkg::seq_state_t state;
	clk_prog_pkg::ratio_t     m_r;
	logic [GW-1:0]            gap_cnt;
	logic [LW-1:0]            lock_cnt;
	logic                     accept;

	// Commands only while idle and the supervisor is done
	assign ready = sys_ready && (state == clk_prog_pkg::IDLE);
	assign accept = cmd_valid && ready;
	// One cycle in DONE gives the pulse
	assign prog_done = (state == clk_prog_pkg::DONE);

	// *************************************************************************
	// State machine
	// *************************************************************************

	always_ff @(posedge IFCLK) begin
		if (rst) begin
			state       <= clk_prog_pkg::IDLE;
			frame_start <= 1'b0;
			prog_err    <= 1'b0;
			gap_cnt     <= '0;
			lock_cnt    <= '0;
		end else begin
			frame_start <= 1'b0;
			case (state)
				clk_prog_pkg::IDLE: begin
					// D frame goes out at once
					if (accept) begin
						state       <= clk_prog_pkg::SEND_D;
						frame_start <= 1'b1;
						prog_err    <= 1'b0;
						gap_cnt     <= '0;
					end
				end
				clk_prog_pkg::SEND_D, clk_prog_pkg::SEND_M, clk_prog_pkg::SEND_GO: begin
					// Nonzero count means the frame is still held back
					if (gap_cnt != '0) begin
						gap_cnt     <= gap_cnt - 1'b1;
						frame_start <= (gap_cnt == GW'(1));
					end else if (frame_end) begin
						lock_cnt <= '0;
						if (state == clk_prog_pkg::SEND_D) begin
							state   <= clk_prog_pkg::SEND_M;
							gap_cnt <= GW'(GAP_WAIT);
						end else if (state == clk_prog_pkg::SEND_M) begin
							state   <= clk_prog_pkg::SEND_GO;
							gap_cnt <= GW'(GAP_WAIT);
						end else begin
							state <= clk_prog_pkg::WAIT_LOCK;
						end
					end
				end
				clk_prog_pkg::WAIT_LOCK: begin
					// Lock shows as progdone_inv low
					if (!progdone_inv) begin
						state <= clk_prog_pkg::DONE;
					end else if (lock_cnt == LW'(LOCK_TIMEOUT - 1)) begin
						state <= clk_prog_pkg::FAIL;
					end else begin
						lock_cnt <= lock_cnt + 1'b1;
					end
				end
				clk_prog_pkg::DONE: state <= clk_prog_pkg::IDLE;
				clk_prog_pkg::FAIL: begin
					// Error stays up until the next command
					prog_err <= 1'b1;
					state    <= clk_prog_pkg::IDLE;
				end
				default: state <= clk_prog_pkg::IDLE;
			endcase
		end
	end

	// Frame contents, the lane stays from the accepted command
	always_ff @(posedge IFCLK) begin
		if (accept) begin
			m_r           <= cmd.m;
			frame.lane    <= cmd.lane;
			frame.opcode  <= clk_prog_pkg::OP_LOAD_D;
			frame.payload <= cmd.d - 8'd1;
			frame.go      <= 1'b0;
		end else if (frame_end && state == clk_prog_pkg::SEND_D) begin
			frame.opcode  <= clk_prog_pkg::OP_LOAD_M;
			frame.payload <= m_r - 8'd1;
		end else if (frame_end && state == clk_prog_pkg::SEND_M) begin
			frame.opcode  <= clk_prog_pkg::OP_GO;
			frame.payload <= '0;
			frame.go      <= 1'b1;
		end
	end

endmodule

// File: src/prog_serializer.sv
`timescale 1ns/1ps

module prog_serializer (
	input  logic                 IFCLK,
	input  logic                 rst,
	input  logic                 frame_start,
	input  clk_prog_pkg::frame_t frame,
	output logic [3:0]           progen,
	output logic                 progdata,
	output logic                 progclk,
	output logic                 frame_end
);

	localparam int FB = clk_prog_pkg::FRAME_BITS;
	localparam int CW = $clog2(FB);

	logic                 fall;
	logic                 accept;
	logic                 start_now;
	logic                 pending;
	logic                 busy;
	logic                 ending;
	clk_prog_pkg::frame_t held;
	clk_prog_pkg::frame_t cur;
	logic [FB-1:0]        word;
	logic [FB-1:0]        shreg;
	logic [CW-1:0]        bits_left;

	// Free-running progclk, half the IFCLK rate
	always_ff @(posedge IFCLK) begin
		if (rst) begin
			progclk <= 1'b0;
		end else begin
			progclk <= ~progclk;
		end
	end

	// This edge drives progclk low, the only edge where lines change
	assign fall = progclk;
	// New frames only while idle
	assign accept = frame_start && !busy && !pending;
	// Start on the strobe itself or on the next falling phase
	assign start_now = fall && (pending || accept);
	// Frame parked in held when the strobe missed a falling phase
	assign cur = pending ? held : frame;
	// Opcode first, then payload, everything LSB first
	assign word = {cur.payload, cur.opcode};

	// *************************************************************************
	// Frame control
	// *************************************************************************

	always_ff @(posedge IFCLK) begin
		if (rst) begin
			pending   <= 1'b0;
			busy      <= 1'b0;
			ending    <= 1'b0;
			frame_end <= 1'b0;
			progen    <= '0;
			progdata  <= 1'b0;
		end else begin
			// frame_end trails the progen drop by one cycle
			frame_end <= ending;
			ending    <= 1'b0;
			if (accept && !fall) begin
				pending <= 1'b1;
			end
			if (start_now) begin
				pending  <= 1'b0;
				busy     <= 1'b1;
				progen   <= 4'b0001 << cur.lane;
				progdata <= word[0];
			end else if (busy && fall) begin
				if (bits_left != '0) begin
					progdata <= shreg[0];
				end else begin
					// Last bit held a full period, release the lane
					busy     <= 1'b0;
					progen   <= '0;
					progdata <= 1'b0;
					ending   <= 1'b1;
				end
			end
		end
	end

	// Shift data path
	always_ff @(posedge IFCLK) begin
		if (accept) begin
			held <= frame;
		end
		if (start_now) begin
			shreg     <= word >> 1;
			// GO is one bit, a load frame is the full ten
			bits_left <= cur.go ? '0 : CW'(FB - 1);
		end else if (busy && fall && bits_left != '0) begin
			shreg     <= shreg >> 1;
			bits_left <= bits_left - 1'b1;
		end
	end

endmodule

// File: src/clk_supervisor.sv
`timescale 1ns/1ps

module clk_supervisor #(
	parameter int RESET_HOLD = 32
) (
	input  logic IFCLK,
	input  logic rst,
	input  logic pll_reset_req,
	output logic pll_reset,
	output logic sys_ready
);

	// Counter width, must hold RESET_HOLD itself
	localparam int HW = $clog2(RESET_HOLD + 1);

	logic [3:0]    delay_line;
	logic          startup_done;
	logic [HW-1:0] hold_cnt;

	// *************************************************************************
	// Start-up delay
	// *************************************************************************

	// Fills with ones over four cycles once rst is released
	always_ff @(posedge IFCLK) begin
		if (rst) begin
			delay_line <= '0;
		end else begin
			delay_line <= {delay_line[2:0], 1'b1};
		end
	end

	// All four stages set
	assign startup_done = &delay_line;

	// *************************************************************************
	// PLL reset hold
	// *************************************************************************

	// Reloaded by rst or by a host request, then runs down to zero
	always_ff @(posedge IFCLK) begin
		if (rst || pll_reset_req) begin
			hold_cnt <= HW'(RESET_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// High as long as the count is running
	assign pll_reset = (hold_cnt != '0);

	// Generators usable once both the delay and the hold are over
	assign sys_ready = startup_done && !pll_reset;

endmodule

// File: src/clk_prog_pkg.sv
package clk_prog_pkg;

	// *************************************************************************
	// Widths and frame encoding
	// *************************************************************************

	// Selects one of the four progen lanes
	typedef logic [1:0] lane_t;

	// M or D value, the wire carries the ratio minus one
	typedef logic [7:0] ratio_t;

	// Frame command, shifted out LSB first ahead of the payload
	typedef logic [1:0] opcode_t;

	// Load D shows up on progdata as 1 then 0
	localparam opcode_t OP_LOAD_D = 2'b01;
	// Load M shows up as 1 then 1
	localparam opcode_t OP_LOAD_M = 2'b11;
	// GO frame is a single zero bit
	localparam opcode_t OP_GO = 2'b00;

	// Two opcode bits plus eight payload bits
	localparam int FRAME_BITS = 10;

	// Host command, lane plus the raw ratios
	typedef struct packed {
		lane_t  lane;
		ratio_t m;
		ratio_t d;
	} prog_cmd_t;

	// One frame as handed to the serializer
	typedef struct packed {
		lane_t   lane;
		opcode_t opcode;
		ratio_t  payload;
		logic    go;
	} frame_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SEND_D,
		SEND_M,
		SEND_GO,
		WAIT_LOCK,
		DONE,
		FAIL
	} seq_state_t;

endpackage
